// File: periph_top.f
+incdir+src
src/periph_pkg.sv
src/wb_reg_decoder.sv
src/gpio_regs.sv
src/irq_gateway.sv
src/irq_target.sv
src/periph_top.sv
bench/tb_clock_gen.sv
bench/tb_periph_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the periph_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps \
        --top-module tb_periph_top -Mdir obj_dir -o sim_tb -f periph_top.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: bench/tb_periph_top.sv
// ------------------------------------------------
// Testbench for periph_top: random Wishbone traffic
// and buttons, checked against a register model.
// ------------------------------------------------

`include "periph_config.svh"

module tb_periph_top;
    timeunit 1ns;
    timeprecision 1ps;
    import periph_pkg::*;

    localparam int n_src       = `PERIPH_NUM_SOURCES;
    localparam int idx_w       = $clog2(n_src);
    localparam int n_led       = 16;
    localparam int n_btn       = 12;
    localparam int n_irq       = 20;
    localparam int total_steps = 3 + n_led + n_btn + n_irq;

    logic       clk;
    logic       rst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    addr_t      wb_adr;
    data_t      wb_dat_w;
    data_t      wb_dat_r;
    logic       wb_ack;
    src_vec_t   btns;
    logic [7:0] leds;
    logic       irq;

    // Register model
    logic [7:0] m_led;
    src_vec_t   m_btn;
    src_vec_t   m_pend;
    src_vec_t   m_insvc;
    src_vec_t   m_en;
    prio_t      m_prio [n_src];
    prio_t      m_thr;

    tb_clock_gen clk_gen (.clk_o(clk));

    periph_top dut0 (
        .clk_i    ( clk      ),
        .rst_n_i  ( rst_n    ),
        .wb_cyc_i ( wb_cyc   ),
        .wb_stb_i ( wb_stb   ),
        .wb_we_i  ( wb_we    ),
        .wb_adr_i ( wb_adr   ),
        .wb_dat_i ( wb_dat_w ),
        .wb_dat_o ( wb_dat_r ),
        .wb_ack_o ( wb_ack   ),
        .btns_i   ( btns     ),
        .leds_o   ( leds     ),
        .irq_o    ( irq      )
    );

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------
    // Wishbone master
    // ------------------------------------------------
    task automatic wait_ack();
        int cycles;
        @(posedge clk);
        #1;
        cycles = 1;
        while (!wb_ack && cycles < 16) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!wb_ack) begin
            $display("Wishbone access to 0x%02h never got an ack", wb_adr);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic bus_write(input addr_t adr, input data_t dat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(input addr_t adr, input data_t expected);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        check_value($sformatf("wb_dat_o at 0x%02h", adr), wb_dat_r, expected);
    endtask

    // ------------------------------------------------
    // Model of gateway and target
    // ------------------------------------------------
    // Idle sources with a high level latch as pending
    task automatic settle();
        repeat (8) @(posedge clk);
        #1;
        m_pend = m_pend | (m_btn & ~m_pend & ~m_insvc);
    endtask

    task automatic drive_buttons(input src_vec_t pattern);
        btns  = pattern;
        m_btn = pattern;
        settle();
    endtask

    // Highest priority first, then lowest source number
    function automatic irq_id_t expected_claim();
        irq_id_t id;
        id = '0;
        for (int p = (1 << `PERIPH_PRIO_W) - 1; p > int'(m_thr); p--) begin
            for (int i = 0; i < n_src; i++) begin
                if (id == '0 && m_pend[idx_w'(i)] && m_en[idx_w'(i)]
                    && int'(m_prio[idx_w'(i)]) == p) begin
                    id = irq_id_t'(i + 1);
                end
            end
        end
        return id;
    endfunction

    task automatic claim_check(output irq_id_t id);
        id = expected_claim();
        read_check(`PERIPH_CLAIM_OFS, data_t'(id));
        if (id != '0) begin
            m_pend  = m_pend & ~src_vec_t'(1 << (int'(id) - 1));
            m_insvc = m_insvc | src_vec_t'(1 << (int'(id) - 1));
        end
    endtask

    task automatic complete(input data_t id);
        bus_write(`PERIPH_CLAIM_OFS, id);
        if (id >= 1 && id <= n_src) begin
            m_insvc = m_insvc & ~src_vec_t'(1 << (int'(id) - 1));
        end
    endtask

    task automatic program_random();
        data_t val;
        for (int i = 0; i < n_src; i++) begin
            val = $urandom;
            bus_write(addr_t'(`PERIPH_PRIO_OFS + 4 * i), val);
            m_prio[idx_w'(i)] = val[`PERIPH_PRIO_W-1:0];
            read_check(addr_t'(`PERIPH_PRIO_OFS + 4 * i), data_t'(m_prio[idx_w'(i)]));
        end
        val = $urandom;
        bus_write(`PERIPH_EN_OFS, val);
        m_en = val[n_src-1:0];
        read_check(`PERIPH_EN_OFS, data_t'(m_en));
        // Low thresholds so that claims happen often
        val = $urandom % 4;
        bus_write(`PERIPH_THR_OFS, val);
        m_thr = val[`PERIPH_PRIO_W-1:0];
        read_check(`PERIPH_THR_OFS, data_t'(m_thr));
    endtask

    initial begin
        repeat (total_steps * 2000) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        data_t   val;
        irq_id_t id;
        int      src;
        data_t   bad_ids [4];
        void'($urandom(57));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        btns     = '0;
        m_led    = '0;
        m_btn    = '0;
        m_pend   = '0;
        m_insvc  = '0;
        m_en     = '0;
        m_thr    = '0;
        for (int i = 0; i < n_src; i++) begin
            m_prio[idx_w'(i)] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // After reset
        check_value("leds_o", data_t'(leds), '0);
        check_value("irq_o", data_t'(irq), '0);
        check_value("wb_ack_o", data_t'(wb_ack), '0);
        read_check(`PERIPH_LED_OFS, '0);
        read_check(`PERIPH_PEND_OFS, '0);
        read_check(`PERIPH_EN_OFS, '0);
        read_check(`PERIPH_THR_OFS, '0);
        read_check(`PERIPH_CLAIM_OFS, '0);

        // LED register and unmapped offsets
        for (int i = 0; i < n_led; i++) begin
            val = $urandom;
            bus_write(`PERIPH_LED_OFS, val);
            m_led = val[7:0];
            check_value("leds_o", data_t'(leds), data_t'(m_led));
            read_check(`PERIPH_LED_OFS, data_t'(m_led));
        end
        bus_write(8'h08, $urandom);
        check_value("leds_o", data_t'(leds), data_t'(m_led));
        read_check(8'h08, '0);
        read_check(8'hB0, '0);
        read_check(8'h82, '0);

        // Buttons, and pending that outlives the level
        for (int i = 0; i < n_btn; i++) begin
            drive_buttons(src_vec_t'($urandom));
            read_check(`PERIPH_BTN_OFS, data_t'(m_btn));
            read_check(`PERIPH_PEND_OFS, data_t'(m_pend));
        end

        // Random priorities, enables and threshold
        for (int r = 0; r < n_irq; r++) begin
            program_random();
            drive_buttons(src_vec_t'($urandom));
            read_check(`PERIPH_PEND_OFS, data_t'(m_pend));
            check_value("irq_o", data_t'(irq), data_t'(expected_claim() != '0));
            claim_check(id);
            settle();
            check_value("irq_o", data_t'(irq), data_t'(expected_claim() != '0));
            read_check(`PERIPH_PEND_OFS, data_t'(m_pend));
            if (id != '0) begin
                complete(data_t'(id));
                settle();
            end
        end

        // ------------------------------------------------
        // One source through claim and complete
        // ------------------------------------------------
        src = $urandom % n_src;
        bus_write(addr_t'(`PERIPH_PRIO_OFS + 4 * src), 32'd7);
        m_prio[idx_w'(src)] = 3'd7;
        bus_write(`PERIPH_EN_OFS, data_t'(1 << src));
        m_en = src_vec_t'(1 << src);
        bus_write(`PERIPH_THR_OFS, '0);
        m_thr = '0;
        drive_buttons(src_vec_t'(1 << src));
        read_check(`PERIPH_PEND_OFS, data_t'(m_pend));
        check_value("irq_o", data_t'(irq), 32'd1);
        claim_check(id);
        settle();
        read_check(`PERIPH_PEND_OFS, data_t'(m_pend));
        check_value("irq_o", data_t'(irq), '0);
        // Last one carries the claimed ID in its low bits
        bad_ids = '{32'd0, 32'd9, 32'd15, data_t'(id) | 32'h10};
        for (int i = 0; i < 4; i++) begin
            complete(bad_ids[i]);
            settle();
            read_check(`PERIPH_PEND_OFS, data_t'(m_pend));
            check_value("irq_o", data_t'(irq), '0);
        end
        complete(data_t'(id));
        settle();
        read_check(`PERIPH_PEND_OFS, data_t'(m_pend));
        check_value("irq_o", data_t'(irq), 32'd1);
        claim_check(id);
        complete(data_t'(id));
        drive_buttons('0);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: bench/tb_clock_gen.sv
// ------------------------------------------------
// Free-running testbench clock, 4 ns period.
// ------------------------------------------------

module tb_clock_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk_o = 1'b0;

    always #2 clk_o = ~clk_o;

endmodule

// File: src/periph_top.sv
// ------------------------------------------------
// Peripheral subsystem top: Wishbone decoder, GPIO
// and a one-target interrupt controller.
// ------------------------------------------------

`include "periph_config.svh"

module periph_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Wishbone slave
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  periph_pkg::addr_t    wb_adr_i,
    input  periph_pkg::data_t    wb_dat_i,
    output periph_pkg::data_t    wb_dat_o,
    output logic                 wb_ack_o,
    // GPIO pins
    input  periph_pkg::src_vec_t btns_i,
    output logic [7:0]           leds_o,
    // Interrupt to the core
    output logic                 irq_o
);
    import periph_pkg::*;

    logic                      gpio_we;
    logic                      gpio_re;
    logic                      irq_we;
    logic                      irq_re;
    logic [`PERIPH_ADDR_W-2:0] reg_addr;
    data_t                     reg_wdata;
    data_t                     gpio_rdata;
    data_t                     irq_rdata;
    src_vec_t                  btn_sync;
    src_vec_t                  pending;
    logic                      claim;
    irq_id_t                   claim_id;
    logic                      complete;
    irq_id_t                   complete_id;

    wb_reg_decoder i_wb_reg_decoder (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .wb_cyc_i     ( wb_cyc_i   ),
        .wb_stb_i     ( wb_stb_i   ),
        .wb_we_i      ( wb_we_i    ),
        .wb_adr_i     ( wb_adr_i   ),
        .wb_dat_i     ( wb_dat_i   ),
        .wb_dat_o     ( wb_dat_o   ),
        .wb_ack_o     ( wb_ack_o   ),
        .gpio_we_o    ( gpio_we    ),
        .gpio_re_o    ( gpio_re    ),
        .irq_we_o     ( irq_we     ),
        .irq_re_o     ( irq_re     ),
        .reg_addr_o   ( reg_addr   ),
        .reg_wdata_o  ( reg_wdata  ),
        .gpio_rdata_i ( gpio_rdata ),
        .irq_rdata_i  ( irq_rdata  )
    );

    gpio_regs i_gpio_regs (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .we_i       ( gpio_we    ),
        .re_i       ( gpio_re    ),
        .addr_i     ( reg_addr   ),
        .wdata_i    ( reg_wdata  ),
        .btns_i     ( btns_i     ),
        .rdata_o    ( gpio_rdata ),
        .leds_o     ( leds_o     ),
        .btn_sync_o ( btn_sync   )
    );

    irq_gateway i_irq_gateway (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .src_i         ( btn_sync    ),
        .claim_i       ( claim       ),
        .claim_id_i    ( claim_id    ),
        .complete_i    ( complete    ),
        .complete_id_i ( complete_id ),
        .pending_o     ( pending     )
    );

    irq_target i_irq_target (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .we_i          ( irq_we      ),
        .re_i          ( irq_re      ),
        .addr_i        ( reg_addr    ),
        .wdata_i       ( reg_wdata   ),
        .pending_i     ( pending     ),
        .rdata_o       ( irq_rdata   ),
        .claim_o       ( claim       ),
        .claim_id_o    ( claim_id    ),
        .complete_o    ( complete    ),
        .complete_id_o ( complete_id ),
        .irq_o         ( irq_o       )
    );

endmodule

// File: src/irq_target.sv
// ------------------------------------------------
// Single interrupt target: priority, enable and
// threshold registers, claim/complete and irq_o.
// ------------------------------------------------

`include "periph_config.svh"

module irq_target (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      we_i,
    input  logic                      re_i,
    input  logic [`PERIPH_ADDR_W-2:0] addr_i,
    input  periph_pkg::data_t         wdata_i,
    input  periph_pkg::src_vec_t      pending_i,
    output periph_pkg::data_t         rdata_o,
    output logic                      claim_o,
    output periph_pkg::irq_id_t       claim_id_o,
    output logic                      complete_o,
    output periph_pkg::irq_id_t       complete_id_o,
    output logic                      irq_o
);
    import periph_pkg::*;

    localparam int IDX_W   = $clog2(`PERIPH_NUM_SOURCES);
    localparam int PRIO_HI = `PERIPH_PRIO_OFS + 4 * `PERIPH_NUM_SOURCES;

    prio_t            prio_q [`PERIPH_NUM_SOURCES];
    src_vec_t         en_q;
    prio_t            thr_q;
    addr_t            full_addr;
    addr_t            prio_rel;
    logic [IDX_W-1:0] prio_idx;
    logic             prio_hit;
    logic             claim_hit;
    logic             id_valid;
    prio_t            best_prio;
    irq_id_t          best_id;

    // ------------------------------------------------
    // Address decode
    // ------------------------------------------------
    assign full_addr = {1'b1, addr_i};
    assign prio_rel  = full_addr - `PERIPH_PRIO_OFS;
    assign prio_idx  = prio_rel[IDX_W+1:2];
    assign prio_hit  = (int'(full_addr) >= int'(`PERIPH_PRIO_OFS))
                    && (int'(full_addr) < PRIO_HI)
                    && (full_addr[1:0] == 2'b00);
    assign claim_hit = (full_addr == `PERIPH_CLAIM_OFS);

    // Completion IDs outside 1..N are dropped
    assign id_valid = (wdata_i >= data_t'(1))
                   && (wdata_i <= data_t'(`PERIPH_NUM_SOURCES));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
                prio_q[i] <= '0;
            end
            en_q  <= '0;
            thr_q <= '0;
        end else if (we_i) begin
            if (prio_hit) begin
                prio_q[prio_idx] <= wdata_i[`PERIPH_PRIO_W-1:0];
            end
            if (full_addr == `PERIPH_EN_OFS) begin
                en_q <= wdata_i[`PERIPH_NUM_SOURCES-1:0];
            end
            if (full_addr == `PERIPH_THR_OFS) begin
                thr_q <= wdata_i[`PERIPH_PRIO_W-1:0];
            end
        end
    end

    // ------------------------------------------------
    // Highest priority above threshold, lowest index on ties
    // ------------------------------------------------
    always_comb begin
        best_prio = thr_q;
        best_id   = '0;
        for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
            if (pending_i[i] && en_q[i] && (prio_q[i] > best_prio)) begin
                best_prio = prio_q[i];
                best_id   = irq_id_t'(i + 1);
            end
        end
    end

    assign claim_id_o    = best_id;
    assign claim_o       = re_i && claim_hit && (best_id != '0);
    assign complete_o    = we_i && claim_hit && id_valid;
    assign complete_id_o = wdata_i[`PERIPH_ID_W-1:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= (best_id != '0);
        end
    end

    // Read mux
    always_comb begin
        rdata_o = '0;
        if (prio_hit) begin
            rdata_o = data_t'(prio_q[prio_idx]);
        end else begin
            case (full_addr)
                `PERIPH_PEND_OFS:  rdata_o = data_t'(pending_i);
                `PERIPH_EN_OFS:    rdata_o = data_t'(en_q);
                `PERIPH_THR_OFS:   rdata_o = data_t'(thr_q);
                `PERIPH_CLAIM_OFS: rdata_o = data_t'(best_id);
                default:           rdata_o = '0;
            endcase
        end
    end

endmodule

// File: src/irq_gateway.sv
// ------------------------------------------------
// Level gateway: latches each source once as pending,
// re-armed only after claim and complete.
// ------------------------------------------------

`include "periph_config.svh"

module irq_gateway (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  periph_pkg::src_vec_t src_i,
    input  logic                 claim_i,
    input  periph_pkg::irq_id_t  claim_id_i,
    input  logic                 complete_i,
    input  periph_pkg::irq_id_t  complete_id_i,
    output periph_pkg::src_vec_t pending_o
);
    import periph_pkg::*;

    src_vec_t pending_q;
    src_vec_t insvc_q;
    src_vec_t claim_hit;
    src_vec_t complete_hit;
    src_vec_t arm;

    // Decode IDs to per-source hits, ID = source + 1
    always_comb begin
        claim_hit    = '0;
        complete_hit = '0;
        for (int i = 0; i < `PERIPH_NUM_SOURCES; i++) begin
            claim_hit[i]    = claim_i && (claim_id_i == irq_id_t'(i + 1));
            complete_hit[i] = complete_i && (complete_id_i == irq_id_t'(i + 1));
        end
    end

    // Only an idle source may latch its level
    assign arm = src_i & ~pending_q & ~insvc_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
            insvc_q   <= '0;
        end else begin
            pending_q <= (pending_q | arm) & ~claim_hit;
            insvc_q   <= (insvc_q | claim_hit) & ~complete_hit;
        end
    end

    assign pending_o = pending_q;

endmodule

// File: src/gpio_regs.sv
// ------------------------------------------------
// LED register and synchronized button inputs.
// ------------------------------------------------

`include "periph_config.svh"

module gpio_regs (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      we_i,
    input  logic                      re_i,
    input  logic [`PERIPH_ADDR_W-2:0] addr_i,
    input  periph_pkg::data_t         wdata_i,
    input  periph_pkg::src_vec_t      btns_i,
    output periph_pkg::data_t         rdata_o,
    output logic [7:0]                leds_o,
    output periph_pkg::src_vec_t      btn_sync_o
);
    import periph_pkg::*;

    addr_t    full_addr;
    src_vec_t btn_meta_q;
    src_vec_t btn_sync_q;

    // GPIO region has bit 7 clear
    assign full_addr = {1'b0, addr_i};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            leds_o     <= '0;
            btn_meta_q <= '0;
            btn_sync_q <= '0;
        end else begin
            btn_meta_q <= btns_i;
            btn_sync_q <= btn_meta_q;
            if (we_i && full_addr == `PERIPH_LED_OFS) begin
                leds_o <= wdata_i[7:0];
            end
        end
    end

    assign btn_sync_o = btn_sync_q;

    always_comb begin
        rdata_o = '0;
        if (re_i) begin
            case (full_addr)
                `PERIPH_LED_OFS: rdata_o = data_t'(leds_o);
                `PERIPH_BTN_OFS: rdata_o = data_t'(btn_sync_q);
                default:         rdata_o = '0;
            endcase
        end
    end

endmodule

// File: src/wb_reg_decoder.sv
// ------------------------------------------------
// Wishbone classic slave, one access in flight.
// Splits each access into a GPIO or IRQ strobe.
// ------------------------------------------------

`include "periph_config.svh"

module wb_reg_decoder (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Wishbone slave
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  periph_pkg::addr_t         wb_adr_i,
    input  periph_pkg::data_t         wb_dat_i,
    output periph_pkg::data_t         wb_dat_o,
    output logic                      wb_ack_o,
    // Register side
    output logic                      gpio_we_o,
    output logic                      gpio_re_o,
    output logic                      irq_we_o,
    output logic                      irq_re_o,
    output logic [`PERIPH_ADDR_W-2:0] reg_addr_o,
    output periph_pkg::data_t         reg_wdata_o,
    input  periph_pkg::data_t         gpio_rdata_i,
    input  periph_pkg::data_t         irq_rdata_i
);
    import periph_pkg::*;

    bus_state_e state_q;
    bus_state_e state_d;
    logic       accept;
    logic       sel_irq;

    // Top address bit picks the region
    assign sel_irq = wb_adr_i[`PERIPH_ADDR_W-1];
    assign accept  = (state_q == BUS_IDLE) && wb_cyc_i && wb_stb_i;

    assign gpio_we_o = accept && wb_we_i && !sel_irq;
    assign gpio_re_o = accept && !wb_we_i && !sel_irq;
    assign irq_we_o  = accept && wb_we_i && sel_irq;
    assign irq_re_o  = accept && !wb_we_i && sel_irq;

    assign reg_addr_o  = wb_adr_i[`PERIPH_ADDR_W-2:0];
    assign reg_wdata_o = wb_dat_i;

    // ------------------------------------------------
    // Bus FSM
    // ------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            BUS_IDLE: if (accept) state_d = BUS_ACK;
            BUS_ACK:  state_d = BUS_IDLE;
            default:  state_d = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= BUS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign wb_ack_o = (state_q == BUS_ACK);

    // Read data sampled in the accept cycle, before side effects land
    always_ff @(posedge clk_i) begin
        if (accept) begin
            wb_dat_o <= sel_irq ? irq_rdata_i : gpio_rdata_i;
        end
    end

endmodule

// File: src/periph_pkg.sv
// ------------------------------------------------
// Shared types of the peripheral block, sized
// from the config header.
// ------------------------------------------------

`include "periph_config.svh"

package periph_pkg;

    // Bus side
    typedef logic [`PERIPH_DATA_W-1:0] data_t;
    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;

    // One bit per interrupt source / button
    typedef logic [`PERIPH_NUM_SOURCES-1:0] src_vec_t;

    // Priority and threshold share a width
    typedef logic [`PERIPH_PRIO_W-1:0] prio_t;

    // 0 means no interrupt
    typedef logic [`PERIPH_ID_W-1:0] irq_id_t;

    // Wishbone decoder FSM
    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_e;

endpackage

// File: src/periph_config.svh
// ------------------------------------------------
// Sizes and register map of the peripheral block.
// Included by the package and by the RTL.
// ------------------------------------------------

`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Widths
`define PERIPH_NUM_SOURCES 8
`define PERIPH_DATA_W      32
`define PERIPH_ADDR_W      8
`define PERIPH_PRIO_W      3
`define PERIPH_ID_W        4

// ------------------------------------------------
// Register offsets
// ------------------------------------------------

// GPIO region, address bit 7 low
`define PERIPH_LED_OFS     8'h00
`define PERIPH_BTN_OFS     8'h04

// Interrupt region, address bit 7 high
// Priority of source i at base + 4*i
`define PERIPH_PRIO_OFS    8'h80
`define PERIPH_PEND_OFS    8'hA0
`define PERIPH_EN_OFS      8'hA4
`define PERIPH_THR_OFS     8'hA8
`define PERIPH_CLAIM_OFS   8'hAC

`endif
